//--- logic/uopDecodePkg.sv
// ====================
// Encodings shared by the micro-op decode stage
// The opcode sits in the low seven bits of every word
// Credit counts assume a single sender and a single receiver
// ====================
`default_nettype none

package uopDecodePkg;

	// ====================
	// Field widths
	// ====================
	localparam int OPC_W = 7;
	localparam int REG_W = 6;
	localparam int FUNC_W = 7;
	localparam int IMM_FIELD_W = 13;
	localparam int IMM_W = 32;
	localparam int UNIT_W = 2;
	localparam int SIZE_W = 2;

	// One word, two readings; the register form keeps rs2 and func
	// where the immediate form keeps its 13-bit constant
	typedef union packed
	{
		struct packed
		{
			logic [FUNC_W-1:0] func;
			logic [REG_W-1:0] rs2;
			logic [REG_W-1:0] rs1;
			logic [REG_W-1:0] rd;
			logic [OPC_W-1:0] opcode;
		} asReg;
		struct packed
		{
			logic [IMM_FIELD_W-1:0] imm;
			logic [REG_W-1:0] rs1;
			logic [REG_W-1:0] rd;
			logic [OPC_W-1:0] opcode;
		} asImm;
	} uopWord;

	// ====================
	// Opcodes
	// ====================
	// Three-register ops, scalar then parallel, byte to octa
	localparam logic [OPC_W-1:0] OP_R3B = 7'h02;
	localparam logic [OPC_W-1:0] OP_R3W = 7'h03;
	localparam logic [OPC_W-1:0] OP_R3T = 7'h04;
	localparam logic [OPC_W-1:0] OP_R3O = 7'h05;
	localparam logic [OPC_W-1:0] OP_R3BP = 7'h0A;
	localparam logic [OPC_W-1:0] OP_R3WP = 7'h0B;
	localparam logic [OPC_W-1:0] OP_R3TP = 7'h0C;
	localparam logic [OPC_W-1:0] OP_R3OP = 7'h0D;
	// Parallel op at the native octa size
	localparam logic [OPC_W-1:0] OP_R3P = 7'h0E;
	// Immediate forms, always octa size
	localparam logic [OPC_W-1:0] OP_ADDI = 7'h20;
	localparam logic [OPC_W-1:0] OP_ANDI = 7'h21;
	localparam logic [OPC_W-1:0] OP_MULI = 7'h26;
	localparam logic [OPC_W-1:0] OP_MULUI = 7'h27;

	// Function codes of the register forms
	localparam logic [FUNC_W-1:0] FN_ADD = 7'h04;
	localparam logic [FUNC_W-1:0] FN_SUB = 7'h05;
	localparam logic [FUNC_W-1:0] FN_AND = 7'h08;
	localparam logic [FUNC_W-1:0] FN_OR = 7'h09;
	localparam logic [FUNC_W-1:0] FN_MUL = 7'h10;
	localparam logic [FUNC_W-1:0] FN_MULU = 7'h11;
	localparam logic [FUNC_W-1:0] FN_MULSU = 7'h12;

	// Execution units
	localparam logic [UNIT_W-1:0] UNIT_ALU = 2'd0;
	localparam logic [UNIT_W-1:0] UNIT_MUL = 2'd1;
	localparam logic [UNIT_W-1:0] UNIT_ILLEGAL = 2'd3;

	// Operand sizes
	localparam logic [SIZE_W-1:0] SZ_BYTE = 2'd0;
	localparam logic [SIZE_W-1:0] SZ_WYDE = 2'd1;
	localparam logic [SIZE_W-1:0] SZ_TETRA = 2'd2;
	localparam logic [SIZE_W-1:0] SZ_OCTA = 2'd3;

	// ====================
	// Queue and credit sizing
	// ====================
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int OUT_CREDITS = 2;
	localparam int OCNT_W = $clog2(OUT_CREDITS + 1);

endpackage

`default_nettype wire

//--- logic/decodeFieldsIf.sv
// ====================
// Decoded operand fields of one micro-op
// All signals are combinational from the producer
// ====================
`timescale 1ns/1ps
`default_nettype none

interface decodeFieldsIf import uopDecodePkg::*; ();

	// Register numbers where rs2 stays zero for immediate forms
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] rs1;
	logic [REG_W-1:0] rs2;
	// Extended immediate that stays zero for register forms
	logic [IMM_W-1:0] imm;
	logic [SIZE_W-1:0] size;
	logic parallel;
	logic hasImm;
	logic illegal;

	// The field decoder drives every field
	modport producer (output rd, rs1, rs2, imm, size, parallel, hasImm, illegal);

	// The decode stage only reads them
	modport consumer (input rd, rs1, rs2, imm, size, parallel, hasImm, illegal);

endinterface

`default_nettype wire

//--- logic/uopQueue.sv
// ====================
// Four-entry input FIFO under an upstream credit loop
// The sender must never push without a credit
// A full queue with a push is not detected
// ====================
`timescale 1ns/1ps
`default_nettype none

module uopQueue import uopDecodePkg::*;
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input uopWord inUop,
	output logic inCredit,
	output logic headValid,
	output uopWord headUop,
	input logic pop
);

	// Storage and bookkeeping
	uopWord mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wrPtr;
	logic [QPTR_W-1:0] rdPtr;
	logic [QCNT_W-1:0] count;
	logic popD;
	logic doPop;

	// A pop only counts when there is something to take
	assign doPop = pop && headValid;

	// ====================
	// Head of the queue
	// ====================
	// The oldest entry is shown without a register stage
	assign headValid = (count != '0);
	assign headUop = mem[rdPtr];

	// Payload storage, written at the write pointer
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			mem[wrPtr] <= inUop;
		end
	end

	// ====================
	// Pointers and occupancy
	// ====================
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			popD <= 1'b0;
		end
		else
		begin
			// Pointers wrap naturally since the depth is a power of two
			if (inValid)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Push and pop in one cycle leave the count unchanged
			count <= count + QCNT_W'(inValid) - QCNT_W'(doPop);
			// One credit goes back a cycle after each pop
			popD <= doPop;
		end
	end

	assign inCredit = popD;

endmodule

`default_nettype wire

//--- logic/mulDecoder.sv
// ====================
// Multiply classification of one micro-op word
// Outputs are purely combinational
// ====================
`timescale 1ns/1ps
`default_nettype none

module mulDecoder import uopDecodePkg::*;
(
	input uopWord uop,
	output logic isMul,
	output logic isMulu,
	output logic isMulsu
);

	logic isR3;
	logic [FUNC_W-1:0] func;

	assign func = uop.asReg.func;

	// All nine three-register opcodes share one function field,
	// scalar and parallel alike
	always_comb
	begin
		case (uop.asReg.opcode)
			OP_R3B, OP_R3W, OP_R3T, OP_R3O: isR3 = 1'b1;
			OP_R3BP, OP_R3WP, OP_R3TP, OP_R3OP: isR3 = 1'b1;
			OP_R3P: isR3 = 1'b1;
			default: isR3 = 1'b0;
		endcase
	end

	// Unsigned multiply comes from the immediate opcode or the
	// register function code
	assign isMulu = (uop.asImm.opcode == OP_MULUI) || (isR3 && func == FN_MULU);

	// Mixed-sign multiply only exists in register form
	assign isMulsu = isR3 && (func == FN_MULSU);

	// Every multiply flavour ends up on the multiply unit
	assign isMul = (uop.asImm.opcode == OP_MULI)
		|| (isR3 && func == FN_MUL)
		|| isMulu
		|| isMulsu;

endmodule

`default_nettype wire

//--- logic/fieldDecoder.sv
// ====================
// Operand field extraction for one micro-op word
// Unknown opcodes and unknown register functions are flagged illegal
// Immediates of unsigned multiplies are zero-extended
// ====================
`timescale 1ns/1ps
`default_nettype none

module fieldDecoder import uopDecodePkg::*;
(
	input uopWord uop,
	input logic isMulu,
	decodeFieldsIf.producer fields
);

	logic regForm;
	logic immForm;
	logic funcKnown;
	logic [IMM_FIELD_W-1:0] immRaw;
	logic [IMM_W-1:0] immExt;

	// ====================
	// Size and lanes
	// ====================
	// Parallel flag and operand size come straight from the opcode
	always_comb
	begin
		case (uop.asReg.opcode)
			OP_R3B: {fields.parallel, fields.size} = {1'b0, SZ_BYTE};
			OP_R3W: {fields.parallel, fields.size} = {1'b0, SZ_WYDE};
			OP_R3T: {fields.parallel, fields.size} = {1'b0, SZ_TETRA};
			OP_R3O: {fields.parallel, fields.size} = {1'b0, SZ_OCTA};
			OP_R3BP: {fields.parallel, fields.size} = {1'b1, SZ_BYTE};
			OP_R3WP: {fields.parallel, fields.size} = {1'b1, SZ_WYDE};
			OP_R3TP: {fields.parallel, fields.size} = {1'b1, SZ_TETRA};
			OP_R3OP: {fields.parallel, fields.size} = {1'b1, SZ_OCTA};
			// Native parallel size is octa
			OP_R3P: {fields.parallel, fields.size} = {1'b1, SZ_OCTA};
			// Immediate forms and unknown opcodes read as scalar octa
			default: {fields.parallel, fields.size} = {1'b0, SZ_OCTA};
		endcase
	end

	// Which view of the word applies
	always_comb
	begin
		case (uop.asReg.opcode)
			OP_R3B, OP_R3W, OP_R3T, OP_R3O: {regForm, immForm} = 2'b10;
			OP_R3BP, OP_R3WP, OP_R3TP, OP_R3OP: {regForm, immForm} = 2'b10;
			OP_R3P: {regForm, immForm} = 2'b10;
			OP_ADDI, OP_ANDI, OP_MULI, OP_MULUI: {regForm, immForm} = 2'b01;
			default: {regForm, immForm} = 2'b00;
		endcase
	end

	// Only the seven defined function codes are legal
	always_comb
	begin
		case (uop.asReg.func)
			FN_ADD, FN_SUB, FN_AND, FN_OR: funcKnown = 1'b1;
			FN_MUL, FN_MULU, FN_MULSU: funcKnown = 1'b1;
			default: funcKnown = 1'b0;
		endcase
	end

	// ====================
	// Immediate extension
	// ====================
	assign immRaw = uop.asImm.imm;

	// Unsigned multiply takes the constant as unsigned, all others sign-extend
	assign immExt = isMulu ? {{(IMM_W - IMM_FIELD_W){1'b0}}, immRaw}
		: {{(IMM_W - IMM_FIELD_W){immRaw[IMM_FIELD_W-1]}}, immRaw};

	// rd and rs1 sit at the same place in both views
	assign fields.rd = uop.asReg.rd;
	assign fields.rs1 = uop.asReg.rs1;
	// The rs2 bits belong to the immediate in the other view
	assign fields.rs2 = regForm ? uop.asReg.rs2 : '0;
	assign fields.imm = immForm ? immExt : '0;
	assign fields.hasImm = immForm;

	// Legal means a known immediate opcode or a known register function
	assign fields.illegal = !(immForm || (regForm && funcKnown));

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
// ====================
// Decode stage under a downstream credit loop
// Pops the queue head whenever a credit is held
// The receiver must return one credit per consumed op
// ====================
`timescale 1ns/1ps
`default_nettype none

module decodeStage import uopDecodePkg::*;
(
	input logic clk,
	input logic arstN,
	input logic headValid,
	input uopWord headUop,
	output logic pop,
	input logic outCredit,
	output logic outValid,
	output logic [UNIT_W-1:0] unit,
	output logic [SIZE_W-1:0] size,
	output logic parallel,
	output logic hasImm,
	output logic isMulu,
	output logic isMulsu,
	output logic [REG_W-1:0] rd,
	output logic [REG_W-1:0] rs1,
	output logic [REG_W-1:0] rs2,
	output logic [IMM_W-1:0] imm
);

	// Combinational results for the word at the queue head
	logic decIsMul;
	logic decIsMulu;
	logic decIsMulsu;
	logic [UNIT_W-1:0] decUnit;

	// Downstream credits still held
	logic [OCNT_W-1:0] credits;

	decodeFieldsIf fieldsBus ();

	// ====================
	// Decoders
	// ====================
	mulDecoder i_mulDec
	(
		.uop(headUop),
		.isMul(decIsMul),
		.isMulu(decIsMulu),
		.isMulsu(decIsMulsu)
	);

	fieldDecoder i_fieldDec
	(
		.uop(headUop),
		.isMulu(decIsMulu),
		.fields(fieldsBus)
	);

	// Illegal wins over multiply, anything else goes to the ALU
	always_comb
	begin
		if (fieldsBus.illegal)
			decUnit = UNIT_ILLEGAL;
		else if (decIsMul)
			decUnit = UNIT_MUL;
		else
			decUnit = UNIT_ALU;
	end

	// ====================
	// Credit loop
	// ====================
	// Take the head as soon as there is one and a credit is held
	assign pop = headValid && (credits != '0);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			credits <= OCNT_W'(OUT_CREDITS);
			outValid <= 1'b0;
		end
		else
		begin
			// A credit returned in the pop cycle is counted as well
			credits <= credits - OCNT_W'(pop) + OCNT_W'(outCredit);
			// One cycle of valid per popped op
			outValid <= pop;
		end
	end

	// Decoded payload, held until the next pop
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			unit <= decUnit;
			size <= fieldsBus.size;
			parallel <= fieldsBus.parallel;
			hasImm <= fieldsBus.hasImm;
			isMulu <= decIsMulu;
			isMulsu <= decIsMulsu;
			rd <= fieldsBus.rd;
			rs1 <= fieldsBus.rs1;
			rs2 <= fieldsBus.rs2;
			imm <= fieldsBus.imm;
		end
	end

endmodule

`default_nettype wire

//--- logic/decodeTop.sv
// ====================
// Micro-op decode top level
// inCredit and outCredit are single-cycle pulses
// The sender starts with four credits
// ====================
`timescale 1ns/1ps
`default_nettype none

module decodeTop import uopDecodePkg::*;
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input logic [31:0] inUop,
	output logic inCredit,
	input logic outCredit,
	output logic outValid,
	output logic [UNIT_W-1:0] unit,
	output logic [SIZE_W-1:0] size,
	output logic parallel,
	output logic hasImm,
	output logic isMulu,
	output logic isMulsu,
	output logic [REG_W-1:0] rd,
	output logic [REG_W-1:0] rs1,
	output logic [REG_W-1:0] rs2,
	output logic [IMM_W-1:0] imm
);

	// Queue head and the pop request between the two blocks
	logic headValid;
	uopWord headUop;
	logic pop;

	uopQueue i_queue
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inUop(inUop),
		.inCredit(inCredit),
		.headValid(headValid),
		.headUop(headUop),
		.pop(pop)
	);

	decodeStage i_stage
	(
		.clk(clk),
		.arstN(arstN),
		.headValid(headValid),
		.headUop(headUop),
		.pop(pop),
		.outCredit(outCredit),
		.outValid(outValid),
		.unit(unit),
		.size(size),
		.parallel(parallel),
		.hasImm(hasImm),
		.isMulu(isMulu),
		.isMulsu(isMulsu),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm)
	);

endmodule

`default_nettype wire

//--- sim/tbClock.sv
// ====================
// Free-running clock with a 40 ns period
// Reset is held low for the first three rising edges
// ====================
`timescale 1ns/1ps
`default_nettype none

module tbClock
(
	output logic clk,
	output logic arstN
);

	// Half period of 20 ns
	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	// Release lands on a rising edge, so the DUT sees reset at that edge
	initial
	begin
		arstN = 1'b0;
		repeat (3) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/decodeTb.sv
// ====================
// Directed tests for the micro-op decode top level
// Expected results come from a reference decode of every sent word
// The scoreboard holds at most EXP_DEPTH ops per run
// ====================
`timescale 1ns/1ps
`default_nettype none

module decodeTb import uopDecodePkg::*; ();

	localparam int CYCLE_NS = 40;
	localparam int EXP_DEPTH = 128;
	localparam int RANDOM_OPS = 40;
	// Directed ops and the random stream get eight cycles per op
	localparam int OP_COUNT = 24 + RANDOM_OPS;
	localparam int WATCH_CYCLES = OP_COUNT * 8 + 200;

	// One decoded op as the DUT presents it
	typedef struct packed
	{
		logic [UNIT_W-1:0] unit;
		logic [SIZE_W-1:0] size;
		logic parallel;
		logic hasImm;
		logic isMulu;
		logic isMulsu;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic [IMM_W-1:0] imm;
	} decodedOp;

	logic clk;
	logic arstN;
	logic inValid;
	logic [31:0] inUop;
	logic inCredit;
	logic outCredit = 1'b0;
	logic outValid;
	logic [UNIT_W-1:0] unit;
	logic [SIZE_W-1:0] size;
	logic parallel;
	logic hasImm;
	logic isMulu;
	logic isMulsu;
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] rs1;
	logic [REG_W-1:0] rs2;
	logic [IMM_W-1:0] imm;

	// Scoreboard is written in send order and read in output order
	decodedOp expArr [EXP_DEPTH];
	int sentCount = 0;
	int outCount = 0;
	// Upstream credits come back as inCredit pulses
	int creditCount = 0;
	// Downstream credits handed back to the DUT
	int retCount = 0;
	logic creditOn = 1'b1;
	logic creditRandom = 1'b0;
	// Monitor and main process keep separate error counts
	int monErrs = 0;
	int mainErrs = 0;
	int errBase = 0;

	tbClock i_clock
	(
		.clk(clk),
		.arstN(arstN)
	);

	decodeTop i_dut
	(
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inUop(inUop),
		.inCredit(inCredit),
		.outCredit(outCredit),
		.outValid(outValid),
		.unit(unit),
		.size(size),
		.parallel(parallel),
		.hasImm(hasImm),
		.isMulu(isMulu),
		.isMulsu(isMulsu),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm)
	);

	// ====================
	// Reference decode
	// ====================
	function automatic decodedOp refDecode(input uopWord w);
		decodedOp e;
		logic [OPC_W-1:0] op;
		logic [FUNC_W-1:0] fn;
		logic r3;
		logic immOp;
		logic mulAny;
		op = w.asReg.opcode;
		fn = w.asReg.func;
		r3 = op inside {OP_R3B, OP_R3W, OP_R3T, OP_R3O, OP_R3BP, OP_R3WP, OP_R3TP,
			OP_R3OP, OP_R3P};
		immOp = op inside {OP_ADDI, OP_ANDI, OP_MULI, OP_MULUI};
		e = '0;
		e.rd = w.asReg.rd;
		e.rs1 = w.asReg.rs1;
		e.size = SZ_OCTA;
		// Only register forms vary in size and lanes
		if (r3)
		begin
			e.rs2 = w.asReg.rs2;
			e.parallel = op inside {OP_R3BP, OP_R3WP, OP_R3TP, OP_R3OP, OP_R3P};
			if (op inside {OP_R3B, OP_R3BP})
				e.size = SZ_BYTE;
			else if (op inside {OP_R3W, OP_R3WP})
				e.size = SZ_WYDE;
			else if (op inside {OP_R3T, OP_R3TP})
				e.size = SZ_TETRA;
		end
		e.isMulu = (op == OP_MULUI) || (r3 && fn == FN_MULU);
		e.isMulsu = r3 && (fn == FN_MULSU);
		mulAny = e.isMulu || e.isMulsu || (op == OP_MULI) || (r3 && fn == FN_MUL);
		// Unsigned multiply keeps its constant unsigned
		if (immOp)
		begin
			e.hasImm = 1'b1;
			e.imm = e.isMulu ? IMM_W'(w.asImm.imm) : IMM_W'(signed'(w.asImm.imm));
		end
		if (!immOp && !(r3 && fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_MUL, FN_MULU,
			FN_MULSU}))
			e.unit = UNIT_ILLEGAL;
		else if (mulAny)
			e.unit = UNIT_MUL;
		else
			e.unit = UNIT_ALU;
		return e;
	endfunction

	function automatic uopWord makeReg(input logic [OPC_W-1:0] op,
		input logic [REG_W-1:0] d, input logic [REG_W-1:0] s1,
		input logic [REG_W-1:0] s2, input logic [FUNC_W-1:0] fn);
		uopWord w;
		w.asReg.opcode = op;
		w.asReg.rd = d;
		w.asReg.rs1 = s1;
		w.asReg.rs2 = s2;
		w.asReg.func = fn;
		return w;
	endfunction

	function automatic uopWord makeImm(input logic [OPC_W-1:0] op,
		input logic [REG_W-1:0] d, input logic [REG_W-1:0] s1,
		input logic [IMM_FIELD_W-1:0] k);
		uopWord w;
		w.asImm.opcode = op;
		w.asImm.rd = d;
		w.asImm.rs1 = s1;
		w.asImm.imm = k;
		return w;
	endfunction

	// The first nine entries are the three-register opcodes
	function automatic logic [OPC_W-1:0] opcodeAt(input int i);
		case (i)
			0: return OP_R3B;
			1: return OP_R3W;
			2: return OP_R3T;
			3: return OP_R3O;
			4: return OP_R3BP;
			5: return OP_R3WP;
			6: return OP_R3TP;
			7: return OP_R3OP;
			8: return OP_R3P;
			9: return OP_ADDI;
			10: return OP_ANDI;
			11: return OP_MULI;
			default: return OP_MULUI;
		endcase
	endfunction

	function automatic logic [FUNC_W-1:0] funcAt(input int i);
		case (i)
			0: return FN_ADD;
			1: return FN_SUB;
			2: return FN_AND;
			3: return FN_OR;
			4: return FN_MUL;
			5: return FN_MULU;
			default: return FN_MULSU;
		endcase
	endfunction

	// Mostly listed opcodes, some raw random ones that are likely illegal
	function automatic uopWord randomWord();
		uopWord w;
		int idx;
		w = uopWord'($urandom);
		idx = $urandom_range(15, 0);
		if (idx < 13)
			w.asReg.opcode = opcodeAt(idx);
		if (idx < 9 && $urandom_range(3, 0) != 0)
			w.asReg.func = funcAt($urandom_range(6, 0));
		return w;
	endfunction

	// ====================
	// Compare tasks
	// ====================
	task checkUnit(input int idx, input logic [UNIT_W-1:0] got, input logic [UNIT_W-1:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t: op %0d unit %0d, expected %0d", $time, idx, got, exp);
			monErrs++;
		end
	endtask

	task checkFields(input int idx, input decodedOp got, input decodedOp exp);
		if (got.rd !== exp.rd || got.rs1 !== exp.rs1 || got.rs2 !== exp.rs2
			|| got.imm !== exp.imm || got.size !== exp.size
			|| got.parallel !== exp.parallel || got.hasImm !== exp.hasImm)
		begin
			$write("error at %0t: op %0d fields rd=%0d rs1=%0d rs2=%0d imm=%h sz=%0d p=%b i=%b",
				$time, idx, got.rd, got.rs1, got.rs2, got.imm, got.size, got.parallel,
				got.hasImm);
			$display(", expected rd=%0d rs1=%0d rs2=%0d imm=%h sz=%0d p=%b i=%b",
				exp.rd, exp.rs1, exp.rs2, exp.imm, exp.size, exp.parallel, exp.hasImm);
			monErrs++;
		end
	endtask

	task checkMul(input int idx, input logic gotU, input logic gotSu, input logic expU,
		input logic expSu);
		if (gotU !== expU || gotSu !== expSu)
		begin
			$display("error at %0t: op %0d isMulu=%b isMulsu=%b, expected %b %b",
				$time, idx, gotU, gotSu, expU, expSu);
			monErrs++;
		end
	endtask

	// Single control bits and event counts, checked from the test tasks
	task checkBit(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
			mainErrs++;
		end
	endtask

	task checkCount(input string what, input int got, input int exp);
		if (got != exp)
		begin
			$display("error at %0t: %s counted %0d, expected %0d", $time, what, got, exp);
			mainErrs++;
		end
	endtask

	// ====================
	// Monitors and credit return
	// ====================
	// Outputs are sampled on the falling edge, well away from updates
	always @(negedge clk)
	begin
		decodedOp got;
		decodedOp exp;
		if (arstN)
		begin
			if (inCredit)
				creditCount++;
			if (outValid)
			begin
				got = {unit, size, parallel, hasImm, isMulu, isMulsu, rd, rs1, rs2, imm};
				if (outCount >= sentCount)
				begin
					$display("An output appeared at %0t with no op outstanding", $time);
					monErrs++;
				end
				else
				begin
					exp = expArr[outCount];
					checkUnit(outCount, got.unit, exp.unit);
					checkFields(outCount, got, exp);
					checkMul(outCount, got.isMulu, got.isMulsu, exp.isMulu, exp.isMulsu);
				end
				outCount++;
			end
		end
	end

	// Hands back one credit per consumed op, at random gaps if asked
	always @(posedge clk)
	begin
		if (creditOn && outCount > retCount
			&& (!creditRandom || $urandom_range(1, 0) == 1))
		begin
			outCredit <= 1'b1;
			retCount++;
		end
		else
		begin
			outCredit <= 1'b0;
		end
	end

	// ====================
	// Stimulus helpers
	// ====================
	// Drives one word on the first rising edge with an upstream credit
	task sendUop(input uopWord w);
		@(posedge clk);
		while (QUEUE_DEPTH - sentCount + creditCount == 0)
		begin
			inValid <= 1'b0;
			@(posedge clk);
		end
		inValid <= 1'b1;
		inUop <= w;
		expArr[sentCount] = refDecode(w);
		sentCount++;
	endtask

	task idleCycle;
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	// Waits until every op is out and every credit of both loops is back
	task drain;
		while (outCount != sentCount || retCount != outCount || creditCount != sentCount)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task endTest(input string name);
		if (monErrs + mainErrs == errBase)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, monErrs + mainErrs - errBase);
		errBase = monErrs + mainErrs;
	endtask

	// ====================
	// Tests
	// ====================
	task testReset;
		wait (arstN === 1'b1);
		repeat (5)
		begin
			@(negedge clk);
			checkBit("outValid", outValid, 1'b0);
			checkBit("inCredit", inCredit, 1'b0);
		end
		endTest("reset");
	endtask

	task automatic testMulu;
		sendUop(makeImm(OP_MULUI, 6'd5, 6'd6, 13'h0123));
		for (int i = 0; i < 9; i++)
			sendUop(makeReg(opcodeAt(i), REG_W'(i), REG_W'(i + 10), REG_W'(i + 20), FN_MULU));
		// Top immediate bits overlay the func field with the unsigned multiply code
		sendUop(makeImm(OP_ADDI, 6'd7, 6'd8, {FN_MULU, 6'd0}));
		idleCycle();
		drain();
		endTest("unsigned multiply");
	endtask

	task testFields;
		sendUop(makeReg(OP_R3W, 6'd1, 6'd2, 6'd3, FN_ADD));
		sendUop(makeReg(OP_R3TP, 6'd63, 6'd0, 6'd31, FN_SUB));
		sendUop(makeReg(OP_R3P, 6'd12, 6'd34, 6'd56, FN_OR));
		// Same negative constant, sign-extended then zero-extended
		sendUop(makeImm(OP_ADDI, 6'd9, 6'd10, 13'h1FF0));
		sendUop(makeImm(OP_MULUI, 6'd11, 6'd12, 13'h1FF0));
		idleCycle();
		drain();
		endTest("fields");
	endtask

	task testIllegal;
		sendUop(makeReg(7'h00, 6'd1, 6'd2, 6'd3, FN_ADD));
		sendUop(makeReg(7'h7F, 6'd4, 6'd5, 6'd6, FN_MUL));
		sendUop(makeReg(OP_R3O, 6'd7, 6'd8, 6'd9, 7'h7F));
		sendUop(makeReg(OP_R3BP, 6'd10, 6'd11, 6'd12, 7'h00));
		idleCycle();
		drain();
		endTest("illegal");
	endtask

	task automatic testBackPressure;
		int baseOut;
		int baseCred;
		int waited;
		creditOn = 1'b0;
		baseOut = outCount;
		baseCred = creditCount;
		for (int i = 0; i < 4; i++)
			sendUop(makeReg(opcodeAt(i), REG_W'(i + 1), 6'd2, 6'd3, FN_AND));
		idleCycle();
		// The pipeline settles within a few cycles once credits run out
		repeat (12) @(negedge clk);
		checkCount("outputs under back-pressure", outCount - baseOut, OUT_CREDITS);
		checkCount("inCredit pulses under back-pressure", creditCount - baseCred, OUT_CREDITS);
		// The two held ops must follow soon after credits flow again
		creditOn = 1'b1;
		waited = 0;
		while (outCount - baseOut < 4 && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		checkCount("outputs after credits return", outCount - baseOut, 4);
		drain();
		endTest("back-pressure");
	endtask

	task testRandom;
		creditRandom = 1'b1;
		repeat (RANDOM_OPS)
		begin
			if ($urandom_range(2, 0) == 0)
				idleCycle();
			sendUop(randomWord());
		end
		idleCycle();
		drain();
		creditRandom = 1'b0;
		endTest("random stream");
	endtask

	initial
	begin
		inValid = 1'b0;
		inUop = '0;
		void'($urandom(81));
		testReset();
		testMulu();
		testFields();
		testIllegal();
		testBackPressure();
		testRandom();
		$display("done: %0d ops sent, %0d outputs checked, %0d errors",
			sentCount, outCount, monErrs + mainErrs);
		if (monErrs + mainErrs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized from the op count of all tests
	initial
	begin
		#(WATCH_CYCLES * CYCLE_NS);
		$display("The run hung and was stopped before the tests finished");
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
logic/uopDecodePkg.sv
logic/decodeFieldsIf.sv
logic/uopQueue.sv
logic/mulDecoder.sv
logic/fieldDecoder.sv
logic/decodeStage.sv
logic/decodeTop.sv
sim/tbClock.sv
sim/decodeTb.sv

//--- Makefile
# Verilator build and run of the micro-op decode testbench
TOP = decodeTb

.PHONY: all lint clean

# Build, run, and fail unless the pass line shows up
all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

obj_dir/V$(TOP): sim.f $(wildcard logic/*.sv sim/*.sv)
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
